/* build.f */
rv_pkg.sv
inst_if.sv
fetch_unit.sv
inst_queue.sv
control.sv
exec_unit.sv
core_top.sv
tb_core.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_core
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb_core.sv */
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam int total_retires  = 6 + 9 + 9 + 9 + 6 + 40;
    localparam int timeout_cycles = 64 * total_retires;

    logic                clk;
    logic                rst;
    logic                run;
    logic                imem_we;
    logic [imem_aw-1:0]  imem_addr;
    logic [31:0]         imem_wdata;
    logic                retire_valid;
    logic [xlen-1:0]     retire_pc;
    logic [4:0]          retire_rd;
    logic [xlen-1:0]     retire_data;
    logic                retire_we;

    logic [31:0] img [imem_depth];   // program image padded with halts
    int          plen;
    logic [31:0] mregs [32];         // reference register file
    logic [31:0] mdmem [dmem_depth];
    logic [31:0] mpc;
    logic [31:0] lfsr = 32'hfef7;
    int          errs;
    int          total_errs;
    int          tests_ok;
    int          tests_bad;
    int          cycles;

    core_top core_top_i (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .retire_we    (retire_we)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois form stepped once per bit handed out
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_r};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm[19:0], rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // isa result for register and immediate arithmetic
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        img[plen] = w;
        plen++;
    endtask

    // core held in reset while the image goes in and released with run high
    task automatic load_program();
        @(posedge clk);
        #2;
        run = 1'b0;
        rst = 1'b1;
        for (int i = 0; i < imem_depth; i++) begin
            if (i >= plen) begin
                img[i] = j_type(32'd0, 5'd0);   // jal x0, 0
            end
            imem_we    = 1'b1;
            imem_addr  = imem_aw'(i);
            imem_wdata = img[i];
            @(posedge clk);
            #2;
        end
        imem_we = 1'b0;
        rst     = 1'b0;
        run     = 1'b1;
        mpc     = '0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
    endtask

    // executes the instruction at mpc in the reference model
    task automatic model_step(output logic we, output logic [4:0] rd,
                              output logic [31:0] data, output logic chk);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next_pc;
        ins     = img[mpc[imem_aw+1:2]];
        a       = mregs[ins[19:15]];
        b       = mregs[ins[24:20]];
        rd      = ins[11:7];
        we      = 1'b0;
        chk     = 1'b0;
        data    = '0;
        res     = '0;
        next_pc = mpc + 4;
        case (ins[6:0])
            op_r: begin
                res = alu_ref(ins[14:12], ins[30], a, b);
                we  = 1'b1;
            end
            op_imm: begin
                res = alu_ref(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
                we  = 1'b1;
            end
            op_load: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                res  = mdmem[addr[5:2]];
                we   = 1'b1;
            end
            op_store: begin
                addr              = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mdmem[addr[5:2]]  = b;
                data              = b;
                chk               = 1'b1;
            end
            op_branch: begin
                if ((a == b) != ins[12]) begin   // funct3 bit 0 picks bne
                    next_pc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            op_lui: begin
                res = {ins[31:12], 12'b0};
                we  = 1'b1;
            end
            op_auipc: begin
                res = mpc + {ins[31:12], 12'b0};
                we  = 1'b1;
            end
            op_jal: begin
                res     = mpc + 4;
                we      = 1'b1;
                next_pc = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: begin
                we = 1'b0;   // unknown word does nothing
            end
        endcase
        if (we && rd != 5'd0) begin
            mregs[rd] = res;
            data      = res;
            chk       = 1'b1;
        end else begin
            we = 1'b0;
        end
        mpc = next_pc;
    endtask

    task automatic expect_retires(input int n);
        int          got;
        logic [31:0] epc;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        chk;
        got = 0;
        while (got < n) begin
            @(negedge clk);   // retire outputs settled since the rising edge
            if (retire_valid) begin
                epc = mpc;
                model_step(we, rd, data, chk);
                if (retire_pc !== epc) begin
                    $display("[FAIL] retire_pc expected %h got %h", epc, retire_pc);
                    errs++;
                end
                if (retire_we !== we) begin
                    $display("[FAIL] retire_we expected %h got %h", we, retire_we);
                    errs++;
                end
                if (chk && retire_data !== data) begin
                    $display("[FAIL] retire_data expected %h got %h", data, retire_data);
                    errs++;
                end
                if (we && retire_rd !== rd) begin
                    $display("[FAIL] retire_rd expected %h got %h", rd, retire_rd);
                    errs++;
                end
                got++;
            end
        end
    endtask

    task automatic report_test(input string name);
        if (errs == 0) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, errs);
            tests_bad++;
        end
        total_errs += errs;
        errs = 0;
    endtask

    task automatic alu_immediates();
        plen = 0;
        emit(i_type(lfsr_take(12), 5'd0, 3'b000, 5'd1, op_imm));   // addi x1
        emit(i_type(lfsr_take(12), 5'd1, 3'b111, 5'd2, op_imm));   // andi
        emit(i_type(lfsr_take(12), 5'd1, 3'b110, 5'd3, op_imm));   // ori
        emit(i_type(lfsr_take(12), 5'd2, 3'b100, 5'd4, op_imm));   // xori
        emit(i_type(lfsr_take(12), 5'd1, 3'b010, 5'd5, op_imm));   // slti
        emit(i_type(lfsr_take(12), 5'd1, 3'b000, 5'd0, op_imm));   // x0 target
        load_program();
        expect_retires(6);
        report_test("alu immediates");
    endtask

    task automatic register_ops();
        plen = 0;
        emit(i_type(32'hffb, 5'd0, 3'b000, 5'd1, op_imm));   // x1 = -5
        emit(i_type(32'd7, 5'd0, 3'b000, 5'd2, op_imm));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));       // add
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));       // sub
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));       // signed -5 < 7
        emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));
        load_program();
        expect_retires(9);
        report_test("register ops");
    endtask

    task automatic load_store();
        plen = 0;
        emit(i_type(lfsr_take(12), 5'd0, 3'b000, 5'd1, op_imm));
        emit(i_type(lfsr_take(12), 5'd0, 3'b000, 5'd2, op_imm));
        emit(i_type(lfsr_take(12), 5'd0, 3'b000, 5'd3, op_imm));
        emit(s_type(32'd4, 5'd1, 5'd0));
        emit(s_type(32'd20, 5'd2, 5'd0));
        emit(s_type(32'd60, 5'd3, 5'd0));   // last word of data memory
        emit(i_type(32'd4, 5'd0, 3'b010, 5'd4, op_load));
        emit(i_type(32'd20, 5'd0, 3'b010, 5'd5, op_load));
        emit(i_type(32'd60, 5'd0, 3'b010, 5'd6, op_load));
        load_program();
        expect_retires(9);
        report_test("load store");
    endtask

    task automatic branch_jump();
        plen = 0;
        emit(i_type(32'd3, 5'd0, 3'b000, 5'd1, op_imm));
        emit(i_type(32'd3, 5'd0, 3'b000, 5'd2, op_imm));
        emit(b_type(32'd8, 5'd2, 5'd1, 3'b000));             // beq taken to 16
        emit(i_type(32'd1, 5'd0, 3'b000, 5'd10, op_imm));    // skipped
        emit(b_type(32'd8, 5'd2, 5'd1, 3'b001));             // bne not taken
        emit(i_type(32'd5, 5'd0, 3'b000, 5'd3, op_imm));
        emit(b_type(32'd8, 5'd3, 5'd1, 3'b001));             // bne taken to 32
        emit(i_type(32'd1, 5'd0, 3'b000, 5'd11, op_imm));    // skipped
        emit(b_type(32'd8, 5'd3, 5'd1, 3'b000));             // beq not taken
        emit(j_type(32'd8, 5'd4));                           // jal to 44 with x4 = 40
        emit(i_type(32'd1, 5'd0, 3'b000, 5'd12, op_imm));    // skipped
        emit(i_type(32'd0, 5'd4, 3'b000, 5'd5, op_imm));     // reads link value
        load_program();
        expect_retires(9);
        report_test("branch jump");
    endtask

    task automatic upper_and_unknown();
        plen = 0;
        emit(u_type(lfsr_take(20), 5'd1, op_lui));
        emit(u_type(lfsr_take(20), 5'd2, op_auipc));
        emit(i_type(32'd77, 5'd0, 3'b000, 5'd3, op_imm));
        emit(32'h0000_0000);                                 // not a valid opcode
        emit({20'h0, 5'd3, 7'b0001011});                     // custom-0 opcode aimed at x3
        emit(i_type(32'd0, 5'd3, 3'b000, 5'd4, op_imm));     // x3 still 77
        load_program();
        expect_retires(6);
        report_test("upper and unknown");
    endtask

    // fills all of imem so fetch wraps and keeps streaming
    task automatic long_stream();
        plen = 0;
        for (int i = 0; i < imem_depth / 2; i++) begin
            emit(i_type(32'd1, 5'd1, 3'b000, 5'd1, op_imm));
            emit(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd2));
        end
        load_program();
        expect_retires(40);
        report_test("long stream");
    endtask

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: expected retires did not arrive within %0d cycles", timeout_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        errs       = 0;
        total_errs = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        alu_immediates();
        register_ops();
        load_store();
        branch_jump();
        upper_and_unknown();
        long_stream();
        $display("tests ok %0d, tests bad %0d, check errors %0d",
                 tests_ok, tests_bad, total_errs);
        if (total_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* core_top.sv */
module core_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       run,
    input  logic                       imem_we,
    input  logic [rv_pkg::imem_aw-1:0] imem_addr,
    input  logic [31:0]                imem_wdata,
    output logic                       retire_valid,
    output logic [rv_pkg::xlen-1:0]    retire_pc,
    output logic [4:0]                 retire_rd,
    output logic [rv_pkg::xlen-1:0]    retire_data,
    output logic                       retire_we
);
    import rv_pkg::*;

    logic            redirect;
    logic [xlen-1:0] redirect_pc;

    inst_if fq ();   // fetch to queue
    inst_if qe ();   // queue to execute

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fq          (fq.producer)
    );

    inst_queue u_queue (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .fq       (fq.consumer),
        .qe       (qe.producer)
    );

    exec_unit u_exec (
        .clk          (clk),
        .rst          (rst),
        .qe           (qe.consumer),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .retire_we    (retire_we)
    );

endmodule

/* exec_unit.sv */
module exec_unit (
    input  logic                    clk,
    input  logic                    rst,
    inst_if.consumer                qe,
    output logic                    redirect,
    output logic [rv_pkg::xlen-1:0] redirect_pc,
    output logic                    retire_valid,
    output logic [rv_pkg::xlen-1:0] retire_pc,
    output logic [4:0]              retire_rd,
    output logic [rv_pkg::xlen-1:0] retire_data,
    output logic                    retire_we
);
    import rv_pkg::*;

    opcode_e         opcode;
    ctrl_t           ctrl;
    logic [31:0]     ins;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] wb_data;
    logic            fire;
    logic            zero;
    logic            wr_en;
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] dmem [dmem_depth];

    assign qe.ready = 1'b1;   // single-cycle execute
    assign fire     = qe.valid && qe.ready;
    assign ins      = qe.instr;
    assign opcode   = opcode_e'(ins[6:0]);
    assign rd       = ins[11:7];
    assign funct3   = ins[14:12];
    assign rs1      = ins[19:15];
    assign rs2      = ins[24:20];

    control u_control (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    always_comb begin
        case (opcode)
            op_store:         imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            op_branch:        imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            op_lui, op_auipc: imm = {ins[31:12], 12'b0};
            op_jal:           imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:          imm = {{20{ins[31]}}, ins[31:20]};   // I-type
        endcase
    end

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];   // x0 reads zero
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign op_a    = (opcode == op_auipc) ? qe.pc : rs1_val;
    assign op_b    = ctrl.alu_src_imm ? imm : rs2_val;

    always_comb begin
        case (ctrl.alu_op)
            aop_branch: alu_res = op_a - op_b;
            aop_pass:   alu_res = op_b;
            aop_funct: begin
                case (funct3)
                    3'b000:  alu_res = (!ctrl.alu_src_imm && ins[30]) ? op_a - op_b : op_a + op_b;
                    3'b010:  alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                    3'b100:  alu_res = op_a ^ op_b;
                    3'b110:  alu_res = op_a | op_b;
                    3'b111:  alu_res = op_a & op_b;
                    default: alu_res = '0;   // shifts and sltu not built
                endcase
            end
            default:    alu_res = op_a + op_b;
        endcase
    end

    assign zero        = (alu_res == '0);
    // funct3[0] splits bne from beq
    assign redirect    = fire && (ctrl.jump || (ctrl.branch && (funct3[0] ? !zero : zero)));
    assign redirect_pc = qe.pc + imm;
    assign load_data   = dmem[alu_res[dmem_aw+1:2]];   // word index from address bits
    assign wb_data     = ctrl.wb_link ? qe.pc + xlen'(4) : (ctrl.mem_rd ? load_data : alu_res);
    assign wr_en       = fire && ctrl.reg_wr && (rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && ctrl.mem_wr) begin
            dmem[alu_res[dmem_aw+1:2]] <= rs2_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= fire;
            retire_we    <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            retire_pc   <= qe.pc;
            retire_rd   <= rd;
            retire_data <= ctrl.mem_wr ? rs2_val : wb_data;   // stores report the stored word
        end
    end

    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst) redirect |-> redirect_pc[1:0] == 2'b00
    );

endmodule

/* control.sv */
module control (
    input  rv_pkg::opcode_e opcode,
    output rv_pkg::ctrl_t   ctrl
);
    import rv_pkg::*;

    always_comb begin
        ctrl        = '0;   // unknown opcodes retire with no effect
        ctrl.alu_op = aop_add;
        case (opcode)
            op_r: begin
                ctrl.reg_wr = 1'b1;
                ctrl.alu_op = aop_funct;
            end
            op_imm: begin
                ctrl.reg_wr      = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = aop_funct;
            end
            op_load: begin
                ctrl.mem_rd      = 1'b1;
                ctrl.reg_wr      = 1'b1;
                ctrl.alu_src_imm = 1'b1;   // base + offset
            end
            op_store: begin
                ctrl.mem_wr      = 1'b1;   // no read, no write-back
                ctrl.alu_src_imm = 1'b1;
            end
            op_branch: begin
                ctrl.branch = 1'b1;        // compare rs1 with rs2
                ctrl.alu_op = aop_branch;
            end
            op_lui: begin
                ctrl.reg_wr      = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = aop_pass;
            end
            op_auipc: begin
                ctrl.reg_wr      = 1'b1;
                ctrl.alu_src_imm = 1'b1;   // pc + upper immediate
            end
            op_jal: begin
                ctrl.reg_wr      = 1'b1;
                ctrl.wb_link     = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.jump        = 1'b1;
            end
            default: begin
                ctrl.reg_wr = 1'b0;
            end
        endcase
    end

endmodule

/* inst_queue.sv */
module inst_queue (
    input  logic     clk,
    input  logic     rst,
    input  logic     redirect,
    inst_if.consumer fq,
    inst_if.producer qe
);
    import rv_pkg::*;

    logic [xlen-1:0]   pc_mem    [queue_depth];
    logic [31:0]       instr_mem [queue_depth];
    logic [qptr_w-1:0] wr_ptr;
    logic [qptr_w-1:0] rd_ptr;
    logic [qptr_w:0]   count;
    logic              push;
    logic              pop;

    assign push     = fq.valid && fq.ready;
    assign pop      = qe.valid && qe.ready;
    assign fq.ready = (count != (qptr_w+1)'(queue_depth));   // low when full
    assign qe.valid = (count != '0);
    assign qe.pc    = pc_mem[rd_ptr];
    assign qe.instr = instr_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]    <= fq.pc;
            instr_mem[wr_ptr] <= fq.instr;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || redirect) begin   // redirect drops every entry and any push
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= (qptr_w+1)'(queue_depth)
    );

endmodule

/* fetch_unit.sv */
module fetch_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       run,
    input  logic                       imem_we,
    input  logic [rv_pkg::imem_aw-1:0] imem_addr,
    input  logic [31:0]                imem_wdata,
    input  logic                       redirect,
    input  logic [rv_pkg::xlen-1:0]    redirect_pc,
    inst_if.producer                   fq
);
    import rv_pkg::*;

    logic [31:0]     imem [imem_depth];
    logic [xlen-1:0] pc;
    logic            valid_q;

    // program load port used only while stopped
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            valid_q <= 1'b0;
        end else if (redirect) begin
            pc      <= redirect_pc;   // offer drops for one cycle on a new target
            valid_q <= 1'b0;
        end else begin
            valid_q <= run;
            if (fq.valid && fq.ready) begin
                pc <= pc + xlen'(4);
            end
        end
    end

    assign fq.valid = valid_q;
    assign fq.pc    = pc;
    assign fq.instr = imem[pc[imem_aw+1:2]];   // wraps modulo imem_depth

    a_no_load_while_run: assert property (
        @(posedge clk) disable iff (rst) !(imem_we && run)
    );

endmodule

/* inst_if.sv */
interface inst_if;
    import rv_pkg::*;

    logic            valid;
    logic            ready;
    logic [xlen-1:0] pc;
    logic [31:0]     instr;

    // transfer on a rising edge with valid and ready both high
    modport producer (
        output valid,
        output pc,
        output instr,
        input  ready
    );

    modport consumer (
        input  valid,
        input  pc,
        input  instr,
        output ready
    );

endinterface

/* rv_pkg.sv */
package rv_pkg;

    localparam int xlen        = 32;
    localparam int imem_depth  = 16;
    localparam int dmem_depth  = 16;
    localparam int imem_aw     = $clog2(imem_depth);
    localparam int dmem_aw     = $clog2(dmem_depth);
    localparam int queue_depth = 4;
    localparam int qptr_w      = $clog2(queue_depth);   // queue pointer width

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        aop_add    = 2'b00,   // address, auipc and jal sums
        aop_funct  = 2'b01,   // operation from funct3/funct7
        aop_branch = 2'b10,   // subtract for compare
        aop_pass   = 2'b11    // immediate straight through
    } alu_op_e;

    typedef struct packed {
        logic    mem_rd;
        logic    mem_wr;
        logic    reg_wr;
        logic    wb_link;       // write pc+4 to rd
        logic    alu_src_imm;   // operand b is the immediate
        alu_op_e alu_op;
        logic    branch;        // conditional branch only
        logic    jump;
    } ctrl_t;

endpackage
